// ==== include/gl_defines.svh ====
`ifndef GL_DEFINES_SVH
`define GL_DEFINES_SVH

// Graduation list depth, a power of two and at least 4
`define GL_NUM_ENTRIES 8

// Index width, log2 of the depth
`define GL_IDX_W 3

// Number of stages in the MUL/DIV lane
`define GL_LONG_LAT 3

`endif

// ==== source/gl_isa_pkg.sv ====
`default_nettype none

package gl_isa_pkg;

    // Legal opcodes, every other code traps at decode
    typedef enum logic [3:0] {
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_XOR = 4'd3,
        OP_MUL = 4'd4,
        OP_DIV = 4'd5
    } opcode_e;

    // Instruction word layout, MSB of each field
    localparam int OPC_MSB = 31;
    localparam int RD_MSB  = 27;
    localparam int A_MSB   = 23;
    localparam int B_MSB   = 11;

    localparam int OPC_W  = 4;
    localparam int RD_W   = 4;
    localparam int OPND_W = 12;  // Unsigned immediates

    typedef logic [31:0] data_t;

endpackage

`default_nettype wire

// ==== source/gl_core_pkg.sv ====
`default_nettype none

package gl_core_pkg;

    `include "gl_defines.svh"

    // Exception causes carried through the list
    typedef enum logic [1:0] {
        EX_NONE     = 2'd0,
        EX_ILLEGAL  = 2'd1,   // Found at decode
        EX_DIV_ZERO = 2'd2    // Found in the long lane
    } ex_cause_e;

    typedef logic [`GL_IDX_W-1:0] gl_idx_t;

    // One slot of the graduation list
    typedef struct packed {
        logic [3:0]          rd;
        gl_isa_pkg::data_t   result;
        ex_cause_e           ex_cause;
        logic                done;      // Result or exception is known
    } gl_entry_t;

endpackage

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic                  gl_full_i,
    input  logic                  flush_i,
    output logic                  stall_o,
    output logic                  dec_valid_o,
    output gl_isa_pkg::opcode_e   dec_op_o,
    output logic [3:0]            dec_rd_o,
    output logic [11:0]           dec_a_o,
    output logic [11:0]           dec_b_o,
    output logic                  dec_long_o,
    output gl_core_pkg::ex_cause_e dec_ex_o
);
    import gl_isa_pkg::*;
    import gl_core_pkg::*;

    opcode_e   op_d;
    logic      long_d;
    ex_cause_e ex_d;
    logic      accept;

    assign op_d = opcode_e'(instr_i[OPC_MSB -: OPC_W]);

    // Sort the opcode into short, long or illegal
    always_comb begin
        long_d = 1'b0;
        ex_d   = EX_NONE;
        case (op_d)
            OP_ADD, OP_SUB, OP_XOR: long_d = 1'b0;
            OP_MUL, OP_DIV:         long_d = 1'b1;
            default:                ex_d   = EX_ILLEGAL;
        endcase
    end

    // Held instruction blocked by a full list, or flush in progress
    assign stall_o = (dec_valid_o & gl_full_i) | flush_i;
    assign accept  = instr_valid_i & ~stall_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dec_valid_o <= 1'b0;
        end else if (flush_i) begin
            dec_valid_o <= 1'b0;  // Younger than the trap, drop it
        end else if (accept) begin
            dec_valid_o <= 1'b1;
        end else if (!gl_full_i) begin
            dec_valid_o <= 1'b0;  // Dispatched, nothing new behind it
        end
    end

    // Payload follows the valid bit
    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_op_o   <= op_d;
            dec_rd_o   <= instr_i[RD_MSB -: RD_W];
            dec_a_o    <= instr_i[A_MSB -: OPND_W];
            dec_b_o    <= instr_i[B_MSB -: OPND_W];
            dec_long_o <= long_d;
            dec_ex_o   <= ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gl_defines.svh"

module exec_unit (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  logic                   issue_i,
    input  gl_isa_pkg::opcode_e    op_i,
    input  logic [11:0]            a_i,
    input  logic [11:0]            b_i,
    input  logic                   long_i,
    input  gl_core_pkg::gl_idx_t   idx_i,
    input  logic                   flush_i,
    output logic                   wb_s_valid_o,
    output gl_core_pkg::gl_idx_t   wb_s_idx_o,
    output gl_isa_pkg::data_t      wb_s_result_o,
    output gl_core_pkg::ex_cause_e wb_s_cause_o,
    output logic                   wb_l_valid_o,
    output gl_core_pkg::gl_idx_t   wb_l_idx_o,
    output gl_isa_pkg::data_t      wb_l_result_o,
    output gl_core_pkg::ex_cause_e wb_l_cause_o
);
    import gl_isa_pkg::*;
    import gl_core_pkg::*;

    localparam int LAT = `GL_LONG_LAT;

    data_t     a_ext;
    data_t     b_ext;
    data_t     s_result_d;
    data_t     l_result_d;
    ex_cause_e l_cause_d;

    logic [LAT-1:0] l_valid_q;
    gl_idx_t        l_idx_q    [LAT];
    data_t          l_result_q [LAT];
    ex_cause_e      l_cause_q  [LAT];

    assign a_ext = {20'd0, a_i};
    assign b_ext = {20'd0, b_i};

    always_comb begin
        case (op_i)
            OP_SUB:  s_result_d = a_ext - b_ext;
            OP_XOR:  s_result_d = a_ext ^ b_ext;
            default: s_result_d = a_ext + b_ext;
        endcase
    end

    always_comb begin
        l_cause_d = EX_NONE;
        if (op_i == OP_MUL) begin
            l_result_d = a_ext * b_ext;
        end else if (b_i == '0) begin
            l_result_d = '0;  // Trap, result is never committed
            l_cause_d  = EX_DIV_ZERO;
        end else begin
            l_result_d = a_ext / b_ext;
        end
    end

    // Short lane, one register stage
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_s_valid_o <= 1'b0;
        end else begin
            wb_s_valid_o <= issue_i & ~long_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_s_idx_o    <= idx_i;
        wb_s_result_o <= s_result_d;
    end

    assign wb_s_cause_o = EX_NONE;

    // Long lane valid shift chain
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            l_valid_q <= '0;
        end else if (flush_i) begin
            l_valid_q <= '0;
        end else begin
            l_valid_q <= {l_valid_q[LAT-2:0], issue_i & long_i};
        end
    end

    always_ff @(posedge clk_i) begin
        l_idx_q[0]    <= idx_i;
        l_result_q[0] <= l_result_d;
        l_cause_q[0]  <= l_cause_d;
        for (int i = 1; i < LAT; i++) begin
            l_idx_q[i]    <= l_idx_q[i-1];
            l_result_q[i] <= l_result_q[i-1];
            l_cause_q[i]  <= l_cause_q[i-1];
        end
    end

    assign wb_l_valid_o  = l_valid_q[LAT-1];
    assign wb_l_idx_o    = l_idx_q[LAT-1];
    assign wb_l_result_o = l_result_q[LAT-1];
    assign wb_l_cause_o  = l_cause_q[LAT-1];

endmodule

`default_nettype wire

// ==== source/graduation_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gl_defines.svh"

module graduation_list (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    // Allocation from decode
    input  logic                   alloc_valid_i,
    input  logic [3:0]             alloc_rd_i,
    input  gl_core_pkg::ex_cause_e alloc_ex_i,
    // Short lane writeback
    input  logic                   wb_s_valid_i,
    input  gl_core_pkg::gl_idx_t   wb_s_idx_i,
    input  gl_isa_pkg::data_t      wb_s_result_i,
    input  gl_core_pkg::ex_cause_e wb_s_cause_i,
    // Long lane writeback
    input  logic                   wb_l_valid_i,
    input  gl_core_pkg::gl_idx_t   wb_l_idx_i,
    input  gl_isa_pkg::data_t      wb_l_result_i,
    input  gl_core_pkg::ex_cause_e wb_l_cause_i,
    output gl_core_pkg::gl_idx_t   alloc_idx_o,
    output logic                   full_o,
    output logic                   flush_o,
    // Commit slots, slot 1 only with slot 0
    output logic                   commit0_valid_o,
    output logic [3:0]             commit0_rd_o,
    output gl_isa_pkg::data_t      commit0_result_o,
    output logic                   commit1_valid_o,
    output logic [3:0]             commit1_rd_o,
    output gl_isa_pkg::data_t      commit1_result_o,
    output logic                   exception_valid_o,
    output gl_core_pkg::ex_cause_e exception_cause_o,
    output logic [3:0]             exception_rd_o
);
    import gl_core_pkg::*;

    localparam int NUM   = `GL_NUM_ENTRIES;
    localparam int CNT_W = `GL_IDX_W + 1;

    gl_entry_t entries [NUM];

    gl_idx_t          head;
    gl_idx_t          head_p1;
    gl_idx_t          tail;
    logic [CNT_W-1:0] count;   // Occupied entries

    gl_entry_t  h0;
    gl_entry_t  h1;
    logic       h0_ready;
    logic       h1_ready;
    logic       ex0;
    logic       ex1;
    logic [1:0] n_commit;

    assign head_p1 = head + gl_idx_t'(1);
    assign h0      = entries[head];
    assign h1      = entries[head_p1];

    // Oldest entry
    assign h0_ready        = (count != '0) && h0.done;
    assign commit0_valid_o = h0_ready && (h0.ex_cause == EX_NONE);
    assign ex0             = h0_ready && (h0.ex_cause != EX_NONE);

    // Second entry only looked at once the head retires
    assign h1_ready        = commit0_valid_o && (count >= CNT_W'(2)) && h1.done;
    assign commit1_valid_o = h1_ready && (h1.ex_cause == EX_NONE);
    assign ex1             = h1_ready && (h1.ex_cause != EX_NONE);

    assign commit0_rd_o     = h0.rd;
    assign commit0_result_o = h0.result;
    assign commit1_rd_o     = h1.rd;
    assign commit1_result_o = h1.result;

    assign exception_valid_o = ex0 | ex1;
    assign exception_cause_o = ex0 ? h0.ex_cause : h1.ex_cause;
    assign exception_rd_o    = ex0 ? h0.rd : h1.rd;

    // Trap at the head drains the whole back end
    assign flush_o = exception_valid_o;

    assign n_commit = {1'b0, commit0_valid_o} + {1'b0, commit1_valid_o};

    assign alloc_idx_o = tail;
    assign full_o      = (count == CNT_W'(NUM - 1));  // One slot kept free

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_o) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + gl_idx_t'(n_commit);
            tail  <= tail + gl_idx_t'(alloc_valid_i);
            count <= count + CNT_W'(alloc_valid_i) - CNT_W'(n_commit);
        end
    end

    // Entry storage, validity comes from count
    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) begin
            entries[tail].rd       <= alloc_rd_i;
            entries[tail].result   <= '0;
            entries[tail].ex_cause <= alloc_ex_i;
            entries[tail].done     <= (alloc_ex_i != EX_NONE);  // Illegal ops never issue
        end

        if (wb_s_valid_i) begin
            entries[wb_s_idx_i].result   <= wb_s_result_i;
            entries[wb_s_idx_i].ex_cause <= wb_s_cause_i;
            entries[wb_s_idx_i].done     <= 1'b1;
        end

        // Lanes never target the same entry in one cycle
        if (wb_l_valid_i) begin
            entries[wb_l_idx_i].result   <= wb_l_result_i;
            entries[wb_l_idx_i].ex_cause <= wb_l_cause_i;
            entries[wb_l_idx_i].done     <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/gl_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gl_core_top (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    output logic                   stall_o,
    output logic                   commit0_valid_o,
    output logic [3:0]             commit0_rd_o,
    output gl_isa_pkg::data_t      commit0_result_o,
    output logic                   commit1_valid_o,
    output logic [3:0]             commit1_rd_o,
    output gl_isa_pkg::data_t      commit1_result_o,
    output logic                   exception_valid_o,
    output gl_core_pkg::ex_cause_e exception_cause_o,
    output logic [3:0]             exception_rd_o
);
    import gl_isa_pkg::*;
    import gl_core_pkg::*;

    logic        dec_valid;
    opcode_e     dec_op;
    logic [3:0]  dec_rd;
    logic [11:0] dec_a;
    logic [11:0] dec_b;
    logic        dec_long;
    ex_cause_e   dec_ex;

    logic        gl_full;
    logic        flush;
    gl_idx_t     alloc_idx;
    logic        issue;
    logic        alloc_valid;

    logic        wb_s_valid;
    gl_idx_t     wb_s_idx;
    data_t       wb_s_result;
    ex_cause_e   wb_s_cause;
    logic        wb_l_valid;
    gl_idx_t     wb_l_idx;
    data_t       wb_l_result;
    ex_cause_e   wb_l_cause;

    assign alloc_valid = dec_valid & ~gl_full;
    assign issue       = alloc_valid & (dec_ex == EX_NONE);  // Traps skip the lanes

    instr_decoder u_decoder (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .gl_full_i    (gl_full),
        .flush_i      (flush),
        .stall_o      (stall_o),
        .dec_valid_o  (dec_valid),
        .dec_op_o     (dec_op),
        .dec_rd_o     (dec_rd),
        .dec_a_o      (dec_a),
        .dec_b_o      (dec_b),
        .dec_long_o   (dec_long),
        .dec_ex_o     (dec_ex)
    );

    exec_unit u_exec (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .issue_i      (issue),
        .op_i         (dec_op),
        .a_i          (dec_a),
        .b_i          (dec_b),
        .long_i       (dec_long),
        .idx_i        (alloc_idx),
        .flush_i      (flush),
        .wb_s_valid_o (wb_s_valid),
        .wb_s_idx_o   (wb_s_idx),
        .wb_s_result_o(wb_s_result),
        .wb_s_cause_o (wb_s_cause),
        .wb_l_valid_o (wb_l_valid),
        .wb_l_idx_o   (wb_l_idx),
        .wb_l_result_o(wb_l_result),
        .wb_l_cause_o (wb_l_cause)
    );

    graduation_list u_gl (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .alloc_valid_i    (alloc_valid),
        .alloc_rd_i       (dec_rd),
        .alloc_ex_i       (dec_ex),
        .wb_s_valid_i     (wb_s_valid),
        .wb_s_idx_i       (wb_s_idx),
        .wb_s_result_i    (wb_s_result),
        .wb_s_cause_i     (wb_s_cause),
        .wb_l_valid_i     (wb_l_valid),
        .wb_l_idx_i       (wb_l_idx),
        .wb_l_result_i    (wb_l_result),
        .wb_l_cause_i     (wb_l_cause),
        .alloc_idx_o      (alloc_idx),
        .full_o           (gl_full),
        .flush_o          (flush),
        .commit0_valid_o  (commit0_valid_o),
        .commit0_rd_o     (commit0_rd_o),
        .commit0_result_o (commit0_result_o),
        .commit1_valid_o  (commit1_valid_o),
        .commit1_rd_o     (commit1_rd_o),
        .commit1_result_o (commit1_result_o),
        .exception_valid_o(exception_valid_o),
        .exception_cause_o(exception_cause_o),
        .exception_rd_o   (exception_rd_o)
    );

endmodule

`default_nettype wire

// ==== dv/gl_core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gl_defines.svh"

module gl_core_asserts (
    input  wire                  clk_i,
    input  wire                  rstn_i,
    input  logic                 alloc_valid_i,
    input  logic                 full_i,
    input  logic                 flush_i,
    input  logic                 commit0_valid_i,
    input  logic                 commit1_valid_i,
    input  logic [`GL_IDX_W:0]   count_i
);
    localparam int CNT_W = `GL_IDX_W + 1;

    int fail_count = 0;  // Read by the testbench at the end of the run

    // Slot 1 only retires behind slot 0
    commit_pair_order: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit1_valid_i |-> commit0_valid_i)
        else begin
            fail_count++;
            $error("commit1 valid without commit0");
        end

    // Occupancy never passes the full level
    count_within_limit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_i <= CNT_W'(`GL_NUM_ENTRIES - 1))
        else begin
            fail_count++;
            $error("occupancy above the full level");
        end

    no_alloc_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        full_i |-> !alloc_valid_i)
        else begin
            fail_count++;
            $error("allocation while the list is full");
        end

    // List is empty after a flush
    quiet_after_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !commit0_valid_i)
        else begin
            fail_count++;
            $error("commit in the cycle after a flush");
        end

endmodule

bind graduation_list gl_core_asserts u_asserts (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .alloc_valid_i  (alloc_valid_i),
    .full_i         (full_o),
    .flush_i        (flush_o),
    .commit0_valid_i(commit0_valid_o),
    .commit1_valid_i(commit1_valid_o),
    .count_i        (count)
);

`default_nettype wire

// ==== dv/gl_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gl_core_tb;
    import gl_isa_pkg::*;
    import gl_core_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 16;

    // Expected retirement record, one per accepted instruction
    typedef struct packed {
        logic [3:0]  rd;
        logic [31:0] result;
        ex_cause_e   cause;
    } exp_t;

    logic        clk_i;
    logic        rstn_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        stall_o;
    logic        commit0_valid_o;
    logic [3:0]  commit0_rd_o;
    data_t       commit0_result_o;
    logic        commit1_valid_o;
    logic [3:0]  commit1_rd_o;
    data_t       commit1_result_o;
    logic        exception_valid_o;
    ex_cause_e   exception_cause_o;
    logic [3:0]  exception_rd_o;

    exp_t        exp_q[$];
    logic [31:0] test_words[$];
    int          test_gaps[$];
    logic        tests_loaded = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          n_commits = 0;
    int          n_dual = 0;
    int          n_except = 0;
    int          n_dropped = 0;
    int          n_stall = 0;
    int          assert_fails;

    gl_core_top UUT (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .stall_o          (stall_o),
        .commit0_valid_o  (commit0_valid_o),
        .commit0_rd_o     (commit0_rd_o),
        .commit0_result_o (commit0_result_o),
        .commit1_valid_o  (commit1_valid_o),
        .commit1_rd_o     (commit1_rd_o),
        .commit1_result_o (commit1_result_o),
        .exception_valid_o(exception_valid_o),
        .exception_cause_o(exception_cause_o),
        .exception_rd_o   (exception_rd_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Reference rule per opcode, operands zero-extended
    function automatic exp_t predict_result(input logic [31:0] word);
        exp_t        e;
        logic [31:0] a;
        logic [31:0] b;
        a        = {20'd0, word[23:12]};
        b        = {20'd0, word[11:0]};
        e.rd     = word[27:24];
        e.result = '0;
        e.cause  = EX_NONE;
        case (word[31:28])
            4'd1: e.result = a + b;
            4'd2: e.result = a - b;
            4'd3: e.result = a ^ b;
            4'd4: e.result = a * b;
            4'd5: begin
                if (b == 32'd0) begin
                    e.cause = EX_DIV_ZERO;
                end else begin
                    e.result = a / b;
                end
            end
            default: e.cause = EX_ILLEGAL;
        endcase
        return e;
    endfunction

    task automatic load_tests();
        int          fd;
        int          n;
        int          gap;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [11:0] a;
        logic [11:0] b;
        string       line;
        fd = $fopen("dv/gl_core_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file dv/gl_core_tests.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %d", op, rd, a, b, gap);
            if (n == 5) begin  // Comment lines match nothing
                test_words.push_back({op, rd, a, b});
                test_gaps.push_back(gap);
            end
        end
        $fclose(fd);
    endtask

    // Idle for the gap, then hold the word until an edge without stall
    task automatic drive_instr(input logic [31:0] word, input int gap);
        if (gap > 0) begin
            #1;
            instr_valid_i = 1'b0;
            repeat (gap) @(posedge clk_i);
        end
        #1;
        instr_valid_i = 1'b1;
        instr_i       = word;
        @(posedge clk_i);
        while (stall_o) @(posedge clk_i);
    endtask

    task automatic compare_commit(input int slot, input logic [3:0] rd, input data_t result);
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("Slot %0d committed rd %h with nothing outstanding", slot, rd);
            other_errors++;
            return;
        end
        e = exp_q.pop_front();
        n_commits++;
        if (e.cause != EX_NONE) begin
            $display("Slot %0d committed rd %h, which should have trapped", slot, rd);
            other_errors++;
        end
        if (rd != e.rd) begin
            $display("CHECK FAILED commit%0d_rd_o: got %h expected %h", slot, rd, e.rd);
            value_errors++;
        end
        if (e.cause == EX_NONE && result != e.result) begin
            $display("CHECK FAILED commit%0d_result_o: got %h expected %h",
                     slot, result, e.result);
            value_errors++;
        end
    endtask

    task automatic handle_exception();
        exp_t e;
        if (!stall_o) begin
            $display("stall_o was low in a flush cycle");
            other_errors++;
        end
        if (exp_q.size() == 0) begin
            $display("Exception reported with nothing outstanding");
            other_errors++;
            return;
        end
        e = exp_q.pop_front();
        n_except++;
        if (e.cause == EX_NONE) begin
            $display("Exception reported for rd %h, which should have committed", e.rd);
            other_errors++;
        end
        if (exception_cause_o != e.cause) begin
            $display("CHECK FAILED exception_cause_o: got %h expected %h",
                     exception_cause_o, e.cause);
            value_errors++;
        end
        if (exception_rd_o != e.rd) begin
            $display("CHECK FAILED exception_rd_o: got %h expected %h", exception_rd_o, e.rd);
            value_errors++;
        end
        // Everything younger was accepted before this edge and gets flushed
        n_dropped += exp_q.size();
        exp_q.delete();
    endtask

    // Retirements first, then the instruction accepted at this edge
    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (stall_o) n_stall++;
            if (commit0_valid_o) compare_commit(0, commit0_rd_o, commit0_result_o);
            if (commit1_valid_o) begin
                n_dual++;
                compare_commit(1, commit1_rd_o, commit1_result_o);
            end
            if (exception_valid_o) handle_exception();
            if (instr_valid_i && !stall_o) exp_q.push_back(predict_result(instr_i));
        end
    end

    initial begin : watchdog
        wait (tests_loaded);
        repeat (40 * test_words.size() + 200) @(posedge clk_i);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("Some tests failed");
        $finish;
    end

    initial begin : stimulus
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(posedge clk_i);
        for (int i = 0; i < test_words.size(); i++) begin
            drive_instr(test_words[i], test_gaps[i]);
        end
        #1;
        instr_valid_i = 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);  // Drain, bounded by the watchdog
        repeat (10) @(posedge clk_i);

        if (n_dual == 0) begin
            $display("No cycle retired two instructions");
            other_errors++;
        end
        if (n_except == 0) begin
            $display("No exception was reported");
            other_errors++;
        end
        if (n_stall == 0) begin
            $display("stall_o never went high");
            other_errors++;
        end
        assert_fails = UUT.u_gl.u_asserts.fail_count;

        $write("Errors: %0d value, %0d other, %0d assertion; ",
               value_errors, other_errors, assert_fails);
        $display("%0d commits (%0d dual), %0d exceptions, %0d dropped",
                 n_commits, n_dual, n_except, n_dropped);
        if (value_errors == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
source/gl_isa_pkg.sv
source/gl_core_pkg.sv
source/instr_decoder.sv
source/exec_unit.sv
source/graduation_list.sv
source/gl_core_top.sv
dv/gl_core_asserts.sv
dv/gl_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the graduation list testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module gl_core_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vgl_core_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

// ==== dv/gl_core_tests.txt ====
# op rd a b gap: op, rd, a, b in hex, then idle cycles before the word (decimal)
# op 1 ADD, 2 SUB, 3 XOR, 4 MUL, 5 DIV, any other code is illegal
1 1 123 045 0
2 2 100 0ff 3
2 3 005 00a 3
3 4 fff 0f0 3
4 5 fff fff 3
5 6 fff 010 3
5 7 007 009 3
4 8 012 034 0
1 9 001 001 0
1 a 002 002 0
3 b 0aa 055 0
1 1 00a 00b 6
f 2 000 000 0
1 3 001 002 0
1 4 003 004 8
4 5 003 005 4
5 6 123 000 0
1 7 001 001 0
2 8 009 003 0
3 9 00f 0f0 8
0 c 111 222 4
1 d 005 005 6
4 1 011 013 6
1 2 0ff 001 0
4 3 07f 07f 0
2 4 000 001 0
5 5 fff 003 0
1 6 800 800 0
3 7 5a5 a5a 0
4 8 abc 010 0
